//--- include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Data path width in bits
`define MIPS_WORD_BITS 32

// Architectural registers
`define MIPS_REG_COUNT 32

// Words in each simulation memory model
`define MIPS_TB_MEM_WORDS 1024

`endif

//--- hdl/mips_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_BITS-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // One fetched word, three ways of reading it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    typedef enum logic [1:0] {
        cls_add,
        cls_sub,
        cls_rtype,
        cls_logic_imm
    } alu_class_t;

    typedef enum logic [3:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        slt,
        sltu
    } alu_op_t;

    typedef struct packed {
        logic       reg_dst;
        logic       branch;
        logic       jump;
        logic       jump_reg;
        logic       mem_read;
        logic       mem_to_reg;
        logic       mem_write;
        logic       alu_src;
        logic       imm_signed;
        logic       reg_write;
        alu_class_t alu_class;
    } ctrl_t;

    // Opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0C;
    localparam logic [5:0] op_ori     = 6'h0D;
    localparam logic [5:0] op_xori    = 6'h0E;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2B;

    // Function codes under op_special
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2A;
    localparam logic [5:0] fn_sltu = 6'h2B;

endpackage

`default_nettype wire

//--- hdl/mips_control.sv
`default_nettype none
`timescale 1ns/100ps

module mips_control (
    input  mips_pkg::instr_t instr,
    output mips_pkg::ctrl_t  ctrl
);

    always_comb begin
        // Anything not listed falls out as a no-op
        ctrl           = '0;
        ctrl.alu_class = mips_pkg::cls_add;

        case (instr.r_fmt.opcode)
            mips_pkg::op_special: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_class = mips_pkg::cls_rtype;
                if (instr.r_fmt.funct == mips_pkg::fn_jr) begin
                    ctrl.jump_reg  = 1'b1;
                    ctrl.reg_write = 1'b0;
                end
            end
            mips_pkg::op_addiu: begin
                ctrl.alu_src    = 1'b1;
                ctrl.imm_signed = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_class = mips_pkg::cls_logic_imm;
            end
            mips_pkg::op_lw: begin
                ctrl.alu_src    = 1'b1;
                ctrl.imm_signed = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            mips_pkg::op_sw: begin
                ctrl.alu_src    = 1'b1;
                ctrl.imm_signed = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            mips_pkg::op_beq: begin
                // Compare by subtraction, zero flag decides
                ctrl.branch     = 1'b1;
                ctrl.imm_signed = 1'b1;
                ctrl.alu_class  = mips_pkg::cls_sub;
            end
            mips_pkg::op_j: begin
                ctrl.jump = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mips_alu_control.sv
`default_nettype none
`timescale 1ns/100ps

module mips_alu_control (
    input  mips_pkg::alu_class_t alu_class,
    input  logic [5:0]           funct,
    input  logic [5:0]           opcode,
    output mips_pkg::alu_op_t    alu_op
);

    always_comb begin
        alu_op = mips_pkg::add;
        case (alu_class)
            mips_pkg::cls_add: alu_op = mips_pkg::add;
            mips_pkg::cls_sub: alu_op = mips_pkg::sub;
            mips_pkg::cls_rtype: begin
                case (funct)
                    mips_pkg::fn_subu: alu_op = mips_pkg::sub;
                    mips_pkg::fn_and:  alu_op = mips_pkg::and_op;
                    mips_pkg::fn_or:   alu_op = mips_pkg::or_op;
                    mips_pkg::fn_xor:  alu_op = mips_pkg::xor_op;
                    mips_pkg::fn_slt:  alu_op = mips_pkg::slt;
                    mips_pkg::fn_sltu: alu_op = mips_pkg::sltu;
                    default:           alu_op = mips_pkg::add;
                endcase
            end
            mips_pkg::cls_logic_imm: begin
                case (opcode)
                    mips_pkg::op_ori:  alu_op = mips_pkg::or_op;
                    mips_pkg::op_xori: alu_op = mips_pkg::xor_op;
                    default:           alu_op = mips_pkg::and_op;
                endcase
            end
            default: alu_op = mips_pkg::add;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mips_alu.sv
`default_nettype none
`timescale 1ns/100ps

module mips_alu (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::word_t   op1,
    input  mips_pkg::word_t   op2,
    output mips_pkg::word_t   result,
    output logic              zero
);

    always_comb begin
        case (alu_op)
            mips_pkg::add: begin
                result = op1 + op2;
            end
            mips_pkg::sub: begin
                result = op1 - op2;
            end
            mips_pkg::and_op: begin
                result = op1 & op2;
            end
            mips_pkg::or_op: begin
                result = op1 | op2;
            end
            mips_pkg::xor_op: begin
                result = op1 ^ op2;
            end
            mips_pkg::slt: begin
                // Signed compare, result is 1 or 0
                result = ($signed(op1) < $signed(op2)) ? 32'd1 : 32'd0;
            end
            mips_pkg::sltu: begin
                result = (op1 < op2) ? 32'd1 : 32'd0;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Used by BEQ
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/mips_regfile.sv
`default_nettype none
`timescale 1ns/100ps

`include "mips_macros.svh"

module mips_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_enable,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  logic               write_en,
    input  mips_pkg::reg_idx_t write_idx,
    input  mips_pkg::word_t    write_data,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    register_v0
);

    mips_pkg::word_t regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && clk_enable && write_idx != '0) begin
            regs[write_idx] <= write_data;
        end
    end

    // $zero reads as zero regardless of storage
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

    // v0 is register 2
    assign register_v0 = regs[2];

endmodule

`default_nettype wire

//--- hdl/mips_pc.sv
`default_nettype none
`timescale 1ns/100ps

`include "mips_macros.svh"

module mips_pc (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clk_enable,
    input  mips_pkg::instr_t  instr,
    input  mips_pkg::ctrl_t   ctrl,
    input  logic              zero,
    input  mips_pkg::word_t   rs_data,
    output mips_pkg::word_t   curr_addr,
    output logic              active
);

    mips_pkg::word_t next_pc;
    mips_pkg::word_t branch_target;
    mips_pkg::word_t jump_target;
    mips_pkg::word_t next_addr;
    logic            halt;

    assign next_pc = curr_addr + 32'd4;

    // Word offset, sign-extended and scaled by four
    assign branch_target = next_pc
                         + {{14{instr.i_fmt.imm[15]}}, instr.i_fmt.imm, 2'b00};
    assign jump_target   = {next_pc[31:28], instr.j_fmt.target, 2'b00};

    always_comb begin
        if (ctrl.branch && zero) begin
            next_addr = branch_target;
        end else if (ctrl.jump) begin
            next_addr = jump_target;
        end else if (ctrl.jump_reg) begin
            next_addr = rs_data;
        end else begin
            next_addr = next_pc;
        end
    end

    // JR to address 0 ends the program
    assign halt = ctrl.jump_reg && (rs_data == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_addr <= `MIPS_RESET_VECTOR;
            active    <= 1'b1;
        end else if (active && clk_enable) begin
            curr_addr <= next_addr;
            if (halt) begin
                active <= 1'b0;
            end
        end
    end

    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        active |-> (curr_addr[1:0] == 2'b00)
    ) else $error("PC not word aligned: %h", curr_addr);

endmodule

`default_nettype wire

//--- hdl/mips_cpu_harvard.sv
`default_nettype none
`timescale 1ns/100ps

module mips_cpu_harvard (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,

    input  logic            clk_enable,

    // Instruction memory, combinational read
    output mips_pkg::word_t instr_address,
    input  mips_pkg::word_t instr_readdata,

    // Data memory, combinational read and write at the edge
    output mips_pkg::word_t data_address,
    output logic            data_write,
    output logic            data_read,
    output mips_pkg::word_t data_writedata,
    input  mips_pkg::word_t data_readdata
);

    mips_pkg::instr_t   instr;
    mips_pkg::ctrl_t    ctrl;
    mips_pkg::alu_op_t  alu_op;
    mips_pkg::word_t    rs_data;
    mips_pkg::word_t    rt_data;
    mips_pkg::word_t    imm_ext;
    mips_pkg::word_t    alu_op2;
    mips_pkg::word_t    alu_result;
    logic               alu_zero;
    mips_pkg::reg_idx_t write_idx;
    mips_pkg::word_t    write_data;
    logic               step_en;

    assign instr = mips_pkg::instr_t'(instr_readdata);

    mips_control u_control (
        .instr (instr),
        .ctrl  (ctrl)
    );

    mips_alu_control u_alu_control (
        .alu_class (ctrl.alu_class),
        .funct     (instr.r_fmt.funct),
        .opcode    (instr.r_fmt.opcode),
        .alu_op    (alu_op)
    );

    // Logical immediates zero-extend, the rest sign-extend
    assign imm_ext = ctrl.imm_signed ? {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm}
                                     : {16'h0000, instr.i_fmt.imm};
    assign alu_op2 = ctrl.alu_src ? imm_ext : rt_data;

    mips_alu u_alu (
        .alu_op (alu_op),
        .op1    (rs_data),
        .op2    (alu_op2),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // Nothing commits while held in reset, halted or stalled
    assign step_en = rst_n && active && clk_enable;

    assign write_idx  = ctrl.reg_dst ? instr.r_fmt.rd : instr.i_fmt.rt;
    assign write_data = ctrl.mem_to_reg ? data_readdata : alu_result;

    mips_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_enable  (clk_enable),
        .rs_idx      (instr.r_fmt.rs),
        .rt_idx      (instr.r_fmt.rt),
        .write_en    (ctrl.reg_write && step_en),
        .write_idx   (write_idx),
        .write_data  (write_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    mips_pc u_pc (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_enable (clk_enable),
        .instr      (instr),
        .ctrl       (ctrl),
        .zero       (alu_zero),
        .rs_data    (rs_data),
        .curr_addr  (instr_address),
        .active     (active)
    );

    assign data_address   = alu_result;
    assign data_writedata = rt_data;
    assign data_write     = ctrl.mem_write && step_en;
    assign data_read      = ctrl.mem_read && step_en;

    mem_read_write_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(data_read && data_write)
    ) else $error("Data read and write asserted together");

endmodule

`default_nettype wire

//--- tests/mips_tb_memory.sv
`default_nettype none
`timescale 1ns/100ps

`include "mips_macros.svh"

module mips_tb_memory (
    input  logic            clk,
    input  mips_pkg::word_t instr_address,
    output mips_pkg::word_t instr_readdata,
    input  mips_pkg::word_t data_address,
    input  logic            data_write,
    input  logic            data_read,
    input  mips_pkg::word_t data_writedata,
    output mips_pkg::word_t data_readdata
);

    localparam int idx_bits = $clog2(`MIPS_TB_MEM_WORDS);

    // Both arrays are loaded by the testbench before each test
    mips_pkg::word_t rom [`MIPS_TB_MEM_WORDS];
    mips_pkg::word_t ram [`MIPS_TB_MEM_WORDS];

    // Low address bits pick the word, so the reset vector lands on word 0
    assign instr_readdata = rom[instr_address[idx_bits+1:2]];
    assign data_readdata  = data_read ? ram[data_address[idx_bits+1:2]] : '0;

    always @(posedge clk) begin
        if (data_write) begin
            ram[data_address[idx_bits+1:2]] <= data_writedata;
        end
    end

endmodule

`default_nettype wire

//--- tests/mips_cpu_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "mips_macros.svh"

module mips_cpu_tb;

    localparam int num_tests  = 6;
    localparam int run_limit  = 100;
    localparam int preset_idx = 4;
    localparam int store_idx  = 8;

    localparam logic [4:0] r_zero = 5'd0;
    localparam logic [4:0] r_v0   = 5'd2;
    localparam logic [4:0] r_t0   = 5'd8;
    localparam logic [4:0] r_t1   = 5'd9;
    localparam logic [4:0] r_t2   = 5'd10;
    localparam logic [4:0] r_t3   = 5'd11;
    localparam logic [4:0] r_t4   = 5'd12;
    localparam logic [4:0] r_t5   = 5'd13;

    // Mode 0 steady enable, 1 random enable, 2 enable held low for a window
    typedef struct packed {
        mips_pkg::word_t [7:0] prog;
        mips_pkg::word_t       preset;
        mips_pkg::word_t       exp_v0;
        mips_pkg::word_t       exp_store;
        logic [1:0]            mode;
    } test_row_t;

    logic            clk;
    logic            rst_n;
    logic            clk_enable;
    logic            active;
    mips_pkg::word_t register_v0;
    mips_pkg::word_t instr_address;
    mips_pkg::word_t instr_readdata;
    mips_pkg::word_t data_address;
    logic            data_write;
    logic            data_read;
    mips_pkg::word_t data_writedata;
    mips_pkg::word_t data_readdata;

    test_row_t rows [num_tests];
    string     names [num_tests];
    int        seed = 32'ha12e_7a55;
    int        test_errors;
    int        passed;

    mips_cpu_harvard DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    mips_tb_memory u_mem (
        .clk            (clk),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    always #2 clk = ~clk;

    function automatic mips_pkg::word_t enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t enc_j(input mips_pkg::word_t addr);
        return {6'h02, addr[27:2]};
    endfunction

    // Background data, unique per byte address
    function automatic mips_pkg::word_t fill_word(input int idx);
        return mips_pkg::word_t'(idx << 2) ^ 32'hA5A5_5A5A;
    endfunction

    task automatic set_row(input int t, input string name, input logic [1:0] mode,
                           input mips_pkg::word_t preset, input mips_pkg::word_t v0,
                           input mips_pkg::word_t store);
        names[t]          = name;
        rows[t].mode      = mode;
        rows[t].preset    = preset;
        rows[t].exp_v0    = v0;
        rows[t].exp_store = store;
    endtask

    task automatic build_table();
        for (int t = 0; t < num_tests; t++) begin
            rows[t] = '0;
        end
        // -5 and 7, then 12 + slt 1 + sltu 0
        rows[0].prog[0] = enc_i(6'h09, r_zero, r_t0, 16'hFFFB);
        rows[0].prog[1] = enc_i(6'h09, r_t0, r_t1, 16'd12);
        rows[0].prog[2] = enc_r(r_t1, r_t0, r_t2, 6'h23);
        rows[0].prog[3] = enc_r(r_t0, r_t1, r_t3, 6'h2A);
        rows[0].prog[4] = enc_r(r_t0, r_t1, r_t4, 6'h2B);
        rows[0].prog[5] = enc_r(r_t2, r_t3, r_t5, 6'h21);
        rows[0].prog[6] = enc_r(r_t5, r_t4, r_v0, 6'h21);
        rows[0].prog[7] = enc_r(r_zero, r_zero, r_zero, 6'h08);
        set_row(0, "arithmetic", 2'd0, '0, 32'd13, fill_word(store_idx));
        // 8F0F, 70F0, 0F00, then 7FF0, 0F00, 70F0
        rows[1].prog[0] = enc_i(6'h0D, r_zero, r_t0, 16'h8F0F);
        rows[1].prog[1] = enc_i(6'h0E, r_t0, r_t1, 16'hFFFF);
        rows[1].prog[2] = enc_i(6'h0C, r_t0, r_t2, 16'h0FF0);
        rows[1].prog[3] = enc_r(r_t1, r_t2, r_t3, 6'h25);
        rows[1].prog[4] = enc_r(r_t3, r_t0, r_t4, 6'h24);
        rows[1].prog[5] = enc_r(r_t3, r_t4, r_t5, 6'h26);
        rows[1].prog[6] = enc_r(r_t5, r_t4, r_v0, 6'h21);
        rows[1].prog[7] = enc_r(r_zero, r_zero, r_zero, 6'h08);
        set_row(1, "logic", 2'd1, '0, 32'h0000_7FF0, fill_word(store_idx));
        // Store through a negative offset, 0x30 - 0x10
        rows[2].prog[0] = enc_i(6'h23, r_zero, r_t0, 16'h0010);
        rows[2].prog[1] = enc_i(6'h09, r_t0, r_t1, 16'hFF88);
        rows[2].prog[2] = enc_r(r_t1, r_t0, r_t2, 6'h21);
        rows[2].prog[3] = enc_i(6'h09, r_zero, r_t3, 16'h0030);
        rows[2].prog[4] = enc_i(6'h2B, r_t3, r_t2, 16'hFFF0);
        rows[2].prog[5] = enc_i(6'h23, r_zero, r_v0, 16'h0020);
        rows[2].prog[6] = enc_r(r_zero, r_zero, r_zero, 6'h08);
        rows[2].prog[7] = enc_i(6'h09, r_zero, r_v0, 16'd1);
        set_row(2, "load store", 2'd1, 32'h1234_5678, 32'h2468_AC78, 32'h2468_AC78);
        // Words 2 and 6 are skipped, 5 + 16
        rows[3].prog[0] = enc_i(6'h09, r_zero, r_v0, 16'd5);
        rows[3].prog[1] = enc_i(6'h04, r_zero, r_t0, 16'd1);
        rows[3].prog[2] = enc_i(6'h09, r_v0, r_v0, 16'd100);
        rows[3].prog[3] = enc_i(6'h04, r_v0, r_zero, 16'd1);
        rows[3].prog[4] = enc_i(6'h09, r_v0, r_v0, 16'd16);
        rows[3].prog[5] = enc_j(`MIPS_RESET_VECTOR + 32'd28);
        rows[3].prog[6] = enc_i(6'h09, r_v0, r_v0, 16'd64);
        rows[3].prog[7] = enc_r(r_zero, r_zero, r_zero, 6'h08);
        set_row(3, "branch and jump", 2'd1, '0, 32'd21, fill_word(store_idx));
        // Halted PC refetches the store at word 0, which must stay idle
        rows[4].prog[0] = enc_i(6'h2B, r_zero, r_v0, 16'h0020);
        rows[4].prog[1] = enc_i(6'h09, r_zero, r_v0, 16'h0077);
        rows[4].prog[2] = enc_r(r_t0, r_zero, r_zero, 6'h08);
        rows[4].prog[3] = enc_i(6'h09, r_v0, r_v0, 16'd1);
        set_row(4, "halt", 2'd1, '0, 32'h0000_0077, '0);
        // Hold window sits on the accumulating ADDIU at word 4
        rows[5] = rows[3];
        rows[5].mode = 2'd2;
        names[5] = "enable hold";
    endtask

    task automatic check_word(input string what, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_active(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t: active is %b, expected %b", $time, got, exp);
            test_errors++;
        end
    endtask

    task automatic run_test(input int t);
        test_row_t   row;
        int          cycles;
        int          late_accesses;
        logic [31:0] r;
        row         = rows[t];
        test_errors = 0;
        rst_n       = 1'b0;
        clk_enable  = 1'b0;
        for (int i = 0; i < `MIPS_TB_MEM_WORDS; i++) begin
            u_mem.rom[i] = '0;
            u_mem.ram[i] = fill_word(i);
        end
        for (int k = 0; k < 8; k++) begin
            u_mem.rom[k] = row.prog[k];
        end
        u_mem.ram[preset_idx] = row.preset;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        cycles = 0;
        while (active && cycles < run_limit) begin
            if (row.mode == 2'd1) begin
                r          = $random(seed);
                clk_enable = (r[1:0] != 2'b00);
            end else begin
                clk_enable = !(row.mode == 2'd2 && cycles >= 3 && cycles < 9);
            end
            @(negedge clk);
            cycles++;
        end

        if (active) begin
            $display("Test %0d: the processor never halted within %0d cycles", t, run_limit);
            test_errors++;
        end else begin
            check_word("v0 at halt", register_v0, row.exp_v0);
            // Clock runs on after the halt
            clk_enable    = 1'b1;
            late_accesses = 0;
            repeat (12) begin
                if (data_write || data_read) begin
                    late_accesses++;
                end
                @(negedge clk);
            end
            check_active(active, 1'b0);
            check_word("PC after halt", instr_address, '0);
            check_word("memory accesses after halt", late_accesses, '0);
            check_word("v0 after halt", register_v0, row.exp_v0);
            check_word("stored word", u_mem.ram[store_idx], row.exp_store);
        end
        if (test_errors == 0) begin
            passed++;
            $display("Test %0d %s: ok", t, names[t]);
        end else begin
            $display("Test %0d %s: mismatch", t, names[t]);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        clk_enable = 1'b0;
        passed     = 0;
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests run %0d, passed %0d, failed %0d", num_tests, passed, num_tests - passed);
        if (passed == num_tests) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hdl/mips_pkg.sv
hdl/mips_control.sv
hdl/mips_alu_control.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_pc.sv
hdl/mips_cpu_harvard.sv
tests/mips_tb_memory.sv
tests/mips_cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mips_cpu_tb -f files.f -o mips_cpu_tb \
    && ./obj_dir/mips_cpu_tb | tee /dev/stderr | grep -q "^Verification passed$" \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }
